/* rtl/fe_settings.svh */
/*
 * front end settings
 * sizes shared by the bundle front end and its testbench
 */
`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// slots per bundle
// the tracker mask table is written for exactly three
`define FE_SLOTS 3

// instruction width of one slot
`define FE_INSN_W 40

// byte address width, bundles sit on 16 byte boundaries
`define FE_ADDR_W 16

// issue queue entries, must be a power of two
`define FE_QDEPTH 8

`endif

/* rtl/fe_pkg.sv */
/*
 * front end package
 * slot opcode encoding, slot mask and count types, and the
 * lowest-slots selection shared by fetch, tracker and queue
 */
`include "fe_settings.svh"

package fe_pkg;

	// opcode field sits in the top nibble of a slot
	localparam int OP_LSB = `FE_INSN_W - 4;
	// static taken hint of a conditional branch
	localparam int HINT_BIT = OP_LSB - 1;

	typedef enum logic [3:0] {
		OP_ALU = 4'h0,
		OP_LD  = 4'h1,
		OP_ST  = 4'h2,
		OP_BR  = 4'h3,
		OP_JC  = 4'h4,
		OP_RET = 4'h5,
		OP_NOP = 4'hf
	} slot_op_e;

	typedef logic [`FE_SLOTS-1:0]  slot_mask_t;
	typedef logic [2:0]            qcnt_t;
	typedef logic [`FE_INSN_W-1:0] insn_t;
	typedef logic [`FE_ADDR_W-1:0] addr_t;

	// ==============================
	// the n lowest set slots of v
	// ==============================
	function automatic slot_mask_t low_slots(slot_mask_t v, qcnt_t n);
		slot_mask_t m;
		m = '0;
		if (n != 3'd0) begin
			case (v)
			3'b011:
				m = (n == 3'd1) ? 3'b001 : 3'b011;
			3'b101:
				m = (n == 3'd1) ? 3'b001 : 3'b101;
			3'b110:
				m = (n == 3'd1) ? 3'b010 : 3'b110;
			3'b111:
				case (n)
				3'd1: m = 3'b001;
				3'd2: m = 3'b011;
				default: m = 3'b111;
				endcase
			// single slot or empty, nothing to pick
			default:
				m = v;
			endcase
		end
		return m;
	endfunction

endpackage

/* rtl/bundle_if.sv */
/*
 * bundle interface
 * a latched bundle with its address, entry mask and hit flag,
 * from fetch to predecode, slot tracker and issue queue
 */
`timescale 1ns/1ps
`include "fe_settings.svh"

interface bundle_if;
	import fe_pkg::*;

	// the three slots of the latched bundle
	insn_t      insn [`FE_SLOTS];
	// aligned address of the latched bundle
	addr_t      ip;
	// entry mask at the fetch address, loaded with the bundle
	slot_mask_t mask;
	// entry mask that travels with the latched bundle
	slot_mask_t maskd;
	// instruction port hit when the bundle was latched
	logic       phit;

	modport src (output insn, ip, mask, maskd, phit);
	modport dst (input insn, ip, mask, maskd, phit);

endinterface

/* rtl/bundle_fetch.sv */
/*
 * bundle fetch
 * instruction pointer, bundle latch and entry mask,
 * redirect on a queued taken control slot
 */
`timescale 1ns/1ps
`include "fe_settings.svh"

module bundle_fetch (
	input  logic               clk,
	input  logic               rst,
	bundle_if.src              bus,
	output fe_pkg::addr_t      imem_addr,
	input  fe_pkg::insn_t      imem_data [`FE_SLOTS],
	input  logic               imem_hit,
	input  logic               nextb,
	output logic               ip_override,
	input  fe_pkg::slot_mask_t slot_jc,
	input  fe_pkg::slot_mask_t slot_ret,
	input  fe_pkg::slot_mask_t take_branch,
	input  fe_pkg::addr_t      targets [`FE_SLOTS],
	input  fe_pkg::addr_t      ret_addr,
	input  fe_pkg::qcnt_t      queued_cnt
);
	import fe_pkg::*;

	addr_t      ip;
	addr_t      seq_ip;
	addr_t      redirect_ip;
	// slots of the latched bundle already taken by the queue
	slot_mask_t done;
	slot_mask_t pend;
	slot_mask_t qm;
	slot_mask_t ctl;
	slot_mask_t hit;

	// bundle base of the fetch address
	assign imem_addr = {ip[`FE_ADDR_W-1:4], 4'b0000};
	assign seq_ip    = {ip[`FE_ADDR_W-1:4] + 1'b1, 4'b0000};

	// entry slot onward, a slot number of 3 has nothing to run
	always_comb begin
		case (ip[3:2])
		2'd0: bus.mask = 3'b111;
		2'd1: bus.mask = 3'b110;
		2'd2: bus.mask = 3'b100;
		default: bus.mask = 3'b000;
		endcase
	end

	// ==============================
	// redirect
	// ==============================
	// own view of the pending slots, matches the tracker while
	// the queue is taking anything
	assign pend = bus.maskd & ~done;
	assign qm   = low_slots(pend, queued_cnt);
	assign ctl  = slot_jc | slot_ret | take_branch;
	// control slots among those queued this cycle
	assign hit  = qm & ctl;

	assign ip_override = |hit;

	// lowest control slot wins, walk down so it is written last
	always_comb begin
		redirect_ip = '0;
		for (int i = `FE_SLOTS - 1; i >= 0; i--) begin
			if (hit[i])
				redirect_ip = slot_ret[i] ? ret_addr : targets[i];
		end
	end

	// ==============================
	// pointer and bundle latch
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			ip        <= '0;
			bus.phit  <= 1'b0;
			bus.maskd <= '0;
			done      <= '0;
		end else begin
			// a miss keeps the pointer so the bundle is refetched
			if (ip_override)
				ip <= redirect_ip;
			else if (nextb && imem_hit)
				ip <= seq_ip;
			if (nextb) begin
				bus.phit  <= imem_hit;
				bus.maskd <= bus.mask;
				done      <= '0;
			end else begin
				done <= done | qm;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (nextb) begin
			bus.insn <= imem_data;
			bus.ip   <= imem_addr;
		end
	end

	// a redirect only comes from slots of a bundle that hit
	a_override_hit: assert property (@(posedge clk) disable iff (rst)
		ip_override |-> bus.phit);

endmodule

/* rtl/slot_predecode.sv */
/*
 * slot predecode
 * flags jump/call, return and predicted-taken branch slots
 * and gives each slot its control target
 */
`timescale 1ns/1ps
`include "fe_settings.svh"

module slot_predecode (
	bundle_if.dst              bus,
	input  fe_pkg::addr_t      ret_addr,
	output fe_pkg::slot_mask_t slot_jc,
	output fe_pkg::slot_mask_t slot_ret,
	output fe_pkg::slot_mask_t take_branch,
	output fe_pkg::addr_t      targets [`FE_SLOTS]
);
	import fe_pkg::*;

	slot_op_e op [`FE_SLOTS];

	always_comb begin
		for (int i = 0; i < `FE_SLOTS; i++) begin
			// opcode from the top nibble
			op[i] = slot_op_e'(bus.insn[i][OP_LSB +: 4]);

			slot_jc[i]  = (op[i] == OP_JC);
			slot_ret[i] = (op[i] == OP_RET);
			// hint bit means nothing outside a branch
			take_branch[i] = (op[i] == OP_BR) && bus.insn[i][HINT_BIT];

			// returns go to the link address, the rest carry
			// an absolute target in the low bits
			if (op[i] == OP_RET)
				targets[i] = ret_addr;
			else
				targets[i] = bus.insn[i][`FE_ADDR_W-1:0];
		end
	end

endmodule

/* rtl/slot_valid.sv */
/*
 * slot valid tracker
 * keeps the slots of the current bundle still waiting for the
 * queue, stomps the bundle behind a redirect, requests the next
 */
`timescale 1ns/1ps
`include "fe_settings.svh"

module slot_valid (
	input  logic               clk,
	input  logic               rst,
	bundle_if.dst              bus,
	input  logic               branchmiss,
	input  fe_pkg::qcnt_t      queued_cnt,
	input  fe_pkg::slot_mask_t slot_jc,
	input  fe_pkg::slot_mask_t slot_ret,
	input  fe_pkg::slot_mask_t take_branch,
	input  logic               ip_override,
	output fe_pkg::slot_mask_t slotv,
	output logic               nextb
);
	import fe_pkg::*;

	// registered pending mask, before hit and stomp gating
	slot_mask_t slotvd;
	// the latched bundle sits behind a redirect
	logic       stomped;
	// registered mask gated by the port hit
	slot_mask_t live;
	// slots up to and including the lowest pending control slot
	slot_mask_t upto;
	// slots the queue takes this cycle
	slot_mask_t qm;
	slot_mask_t ctl;
	// what is left after this cycle
	slot_mask_t slot_rem;
	logic       stomp_next;

	// ==============================
	// pending this cycle
	// ==============================
	assign ctl  = slot_jc | slot_ret | take_branch;
	assign live = slotvd & {`FE_SLOTS{bus.phit}};

	// nothing behind the first pending control slot is offered
	always_comb begin
		if (live[0] && ctl[0])
			upto = 3'b001;
		else if (live[1] && ctl[1])
			upto = 3'b011;
		else
			upto = 3'b111;
	end

	// a missed or stomped bundle offers nothing
	assign slotv = stomped ? '0 : (live & upto);

	// queue takes the lowest pending slots
	assign qm = low_slots(slotv, queued_cnt);

	// a queued control slot redirects fetch
	// the rest of this bundle and the one behind it are dead
	assign stomp_next = ip_override && |(qm & ctl);

	always_comb begin
		if (stomp_next)
			slot_rem = '0;
		else
			slot_rem = slotv & ~qm;
	end

	// ask for the next bundle once nothing is left
	// also true straight out of reset since slotvd is clear
	assign nextb = (slot_rem == '0);

	// ==============================
	// state
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			slotvd  <= '0;
			stomped <= 1'b0;
		end else begin
			if (nextb) begin
				// fresh bundle from the entry slot onward
				slotvd  <= bus.mask;
				stomped <= stomp_next;
			end else if (branchmiss) begin
				// mispredict kills whatever is left
				slotvd <= '0;
			end else begin
				slotvd <= slot_rem;
			end
		end
	end

	// pending slots never reach below the entry slot
	a_slotv_in_mask: assert property (@(posedge clk) disable iff (rst)
		(slotv & ~bus.maskd) == '0);

endmodule

/* rtl/issue_queue.sv */
/*
 * issue queue
 * circular buffer taking up to three slots a cycle in slot
 * order, with the head mirrored out on each dequeue
 */
`timescale 1ns/1ps
`include "fe_settings.svh"

module issue_queue (
	input  logic                         clk,
	input  logic                         rst,
	bundle_if.dst                        bus,
	input  fe_pkg::slot_mask_t           slotv,
	input  logic                         deq,
	output fe_pkg::qcnt_t                queued_cnt,
	output logic                         enq_valid,
	output fe_pkg::insn_t                enq_insn,
	output fe_pkg::addr_t                enq_addr,
	output logic [$clog2(`FE_QDEPTH):0] q_count
);
	import fe_pkg::*;

	localparam int PW = $clog2(`FE_QDEPTH);

	insn_t       insn_mem [`FE_QDEPTH];
	addr_t       addr_mem [`FE_QDEPTH];
	logic [PW-1:0] head;
	logic [PW-1:0] tail;
	logic [PW:0]   count;
	logic [PW:0]   space;
	logic [1:0]    npend;
	logic          pop;
	slot_mask_t    qm;
	// slot number feeding the k-th write
	logic [1:0]    src [`FE_SLOTS];

	// ==============================
	// accept
	// ==============================
	assign space = (PW + 1)'(`FE_QDEPTH) - count;
	assign npend = 2'($countones(slotv));

	// as many pending slots as fit, space counted before dequeue
	always_comb begin
		if (space >= (PW + 1)'(npend))
			queued_cnt = qcnt_t'(npend);
		else
			queued_cnt = qcnt_t'(space);
	end

	assign qm = low_slots(slotv, queued_cnt);

	// pack the taken slots down, lowest first
	always_comb begin
		int j;
		j = 0;
		for (int k = 0; k < `FE_SLOTS; k++)
			src[k] = 2'(k);
		for (int i = 0; i < `FE_SLOTS; i++) begin
			if (qm[i]) begin
				src[j] = 2'(i);
				j++;
			end
		end
	end

	assign pop     = deq && (count != '0);
	assign q_count = count;

	// ==============================
	// storage
	// ==============================
	always_ff @(posedge clk) begin
		for (int k = 0; k < `FE_SLOTS; k++) begin
			if (k < int'(queued_cnt)) begin
				// pointer wraps since depth is a power of two
				insn_mem[tail + PW'(k)] <= bus.insn[src[k]];
				addr_mem[tail + PW'(k)] <= {bus.ip[`FE_ADDR_W-1:4], src[k], 2'b00};
			end
		end
		if (pop) begin
			enq_insn <= insn_mem[head];
			enq_addr <= addr_mem[head];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			enq_valid <= 1'b0;
		end else begin
			tail      <= tail + PW'(queued_cnt);
			head      <= head + PW'(pop);
			count     <= count + (PW + 1)'(queued_cnt) - (PW + 1)'(pop);
			enq_valid <= pop;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		q_count <= (PW + 1)'(`FE_QDEPTH));

	// a beat out means there was something at the head
	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		enq_valid |-> $past(q_count) != '0);

endmodule

/* rtl/front_end_top.sv */
/*
 * bundle front end top
 * fetch, predecode, slot tracker and issue queue
 */
`timescale 1ns/1ps
`include "fe_settings.svh"

module front_end_top (
	input  logic                         clk,
	input  logic                         rst,
	output fe_pkg::addr_t                imem_addr,
	input  fe_pkg::insn_t                imem_data [`FE_SLOTS],
	input  logic                         imem_hit,
	input  logic                         deq,
	input  logic                         branchmiss,
	input  fe_pkg::addr_t                ret_addr,
	output logic                         enq_valid,
	output fe_pkg::insn_t                enq_insn,
	output fe_pkg::addr_t                enq_addr,
	output logic [$clog2(`FE_QDEPTH):0] q_count
);
	import fe_pkg::*;

	// latched bundle, shared by all four blocks
	bundle_if bus ();

	logic       nextb;
	logic       ip_override;
	slot_mask_t slot_jc;
	slot_mask_t slot_ret;
	slot_mask_t take_branch;
	slot_mask_t slotv;
	qcnt_t      queued_cnt;
	addr_t      targets [`FE_SLOTS];

	bundle_fetch i_bundle_fetch (
		.clk         (clk),
		.rst         (rst),
		.bus         (bus.src),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.imem_hit    (imem_hit),
		.nextb       (nextb),
		.ip_override (ip_override),
		.slot_jc     (slot_jc),
		.slot_ret    (slot_ret),
		.take_branch (take_branch),
		.targets     (targets),
		.ret_addr    (ret_addr),
		.queued_cnt  (queued_cnt)
	);

	slot_predecode i_slot_predecode (
		.bus         (bus.dst),
		.ret_addr    (ret_addr),
		.slot_jc     (slot_jc),
		.slot_ret    (slot_ret),
		.take_branch (take_branch),
		.targets     (targets)
	);

	slot_valid i_slot_valid (
		.clk         (clk),
		.rst         (rst),
		.bus         (bus.dst),
		.branchmiss  (branchmiss),
		.queued_cnt  (queued_cnt),
		.slot_jc     (slot_jc),
		.slot_ret    (slot_ret),
		.take_branch (take_branch),
		.ip_override (ip_override),
		.slotv       (slotv),
		.nextb       (nextb)
	);

	issue_queue i_issue_queue (
		.clk        (clk),
		.rst        (rst),
		.bus        (bus.dst),
		.slotv      (slotv),
		.deq        (deq),
		.queued_cnt (queued_cnt),
		.enq_valid  (enq_valid),
		.enq_insn   (enq_insn),
		.enq_addr   (enq_addr),
		.q_count    (q_count)
	);

endmodule

/* testbench/tb_front_end.sv */
/*
 * bundle front end testbench
 * instruction memory model, stimulus rows and a reference walk
 * of the program that every dequeued slot is compared against
 */
`timescale 1ns/1ps
`include "fe_settings.svh"

module tb_front_end;
	import fe_pkg::*;

	localparam int    PERIOD     = 40;
	localparam int    RESET_CYC  = 8;
	localparam int    NUM_ROWS   = 3;
	localparam int    ROW_BEATS  = 45;
	localparam int    ROW_CYCLES = 200;
	localparam int    NBUNDLES   = 256;
	localparam addr_t RET_ADDR   = 16'h0408;

	logic                        clk;
	logic                        rst;
	addr_t                       imem_addr;
	insn_t                       imem_data [`FE_SLOTS];
	logic                        imem_hit;
	logic                        deq;
	logic                        branchmiss;
	addr_t                       ret_addr;
	logic                        enq_valid;
	insn_t                       enq_insn;
	addr_t                       enq_addr;
	logic [$clog2(`FE_QDEPTH):0] q_count;

	// program image, three slots per 16 byte bundle
	insn_t mem [NBUNDLES][`FE_SLOTS];
	// cycles the port misses once the address moves onto a bundle
	int    miss_wait [NBUNDLES];

	// stimulus rows: start address, deq held until full, slots before a branchmiss
	addr_t row_start [NUM_ROWS];
	logic  row_hold [NUM_ROWS];
	int    row_bm [NUM_ROWS];

	// expected slot stream of the running row
	addr_t exp_addr [$];
	insn_t exp_insn [$];

	addr_t last_addr;
	int    stable;
	int    value_errors;
	int    level_errors;
	int    beats_total;

	front_end_top i_front_end_top (
		.clk        (clk),
		.rst        (rst),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.imem_hit   (imem_hit),
		.deq        (deq),
		.branchmiss (branchmiss),
		.ret_addr   (ret_addr),
		.enq_valid  (enq_valid),
		.enq_insn   (enq_insn),
		.enq_addr   (enq_addr),
		.q_count    (q_count)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// each row gets a fixed budget of cycles
	initial begin
		#(NUM_ROWS * ROW_CYCLES * PERIOD);
		$display("timeout: the slot stream stopped before all rows finished");
		$display("CHECKS FAILED");
		$finish;
	end

	// ==============================
	// instruction memory
	// ==============================
	// hit goes high once the address has been stable for miss_wait cycles
	always @(negedge clk) begin
		if (imem_addr !== last_addr) begin
			last_addr = imem_addr;
			stable = 0;
		end else begin
			stable = stable + 1;
		end
		if ($isunknown(imem_addr)) begin
			imem_hit = 1'b0;
			for (int s = 0; s < `FE_SLOTS; s++)
				imem_data[s] = '0;
		end else begin
			imem_hit = (stable >= miss_wait[imem_addr[11:4]]);
			for (int s = 0; s < `FE_SLOTS; s++)
				imem_data[s] = mem[imem_addr[11:4]][s];
		end
	end

	// plain ALU slot, payload from the whole slot address
	function automatic insn_t fill_insn(addr_t a);
		return {OP_ALU, 4'h0, a ^ 16'h3c5a, a};
	endfunction

	function automatic insn_t ctl_insn(slot_op_e op, logic hint, addr_t tgt, addr_t a);
		return {op, hint, 3'b000, a, tgt};
	endfunction

	task automatic set_slot(addr_t a, insn_t w);
		mem[a[11:4]][a[3:2]] = w;
	endtask

	task automatic load_program();
		addr_t a;
		for (int b = 0; b < NBUNDLES; b++) begin
			miss_wait[b] = 0;
			for (int s = 0; s < `FE_SLOTS; s++) begin
				a = addr_t'(b * 16 + s * 4);
				mem[b][s] = fill_insn(a);
			end
		end
		// taken branch in slot 0, 0x150 behind it gets stomped
		set_slot(16'h0140, ctl_insn(OP_BR, 1'b1, 16'h0200, 16'h0140));
		// jump/call in slot 1 into slot 1 of 0x300
		set_slot(16'h0214, ctl_insn(OP_JC, 1'b0, 16'h0304, 16'h0214));
		// return in slot 2, goes to ret_addr
		set_slot(16'h0318, ctl_insn(OP_RET, 1'b0, 16'h0000, 16'h0318));
		// hint clear, falls through
		set_slot(16'h0410, ctl_insn(OP_BR, 1'b0, 16'h0600, 16'h0410));
		set_slot(16'h0448, ctl_insn(OP_JC, 1'b0, 16'h0500, 16'h0448));
		// two misses before 0x420 arrives
		miss_wait[8'h42] = 2;
	endtask

	task automatic fill_rows();
		// aligned start, deq always high
		row_start[0] = 16'h0100;
		row_hold[0] = 1'b0;
		row_bm[0] = 0;
		// unaligned start, queue filled before draining
		row_start[1] = 16'h0104;
		row_hold[1] = 1'b1;
		row_bm[1] = 0;
		// branchmiss once the queue is full
		row_start[2] = 16'h0100;
		row_hold[2] = 1'b1;
		row_bm[2] = `FE_QDEPTH;
	endtask

	// ==============================
	// reference walk
	// ==============================
	// slots in order from the entry slot, taken control ends the bundle
	task automatic build_expected(int bm_at);
		addr_t pc;
		insn_t w;
		logic  dropped;
		exp_addr.delete();
		exp_insn.delete();
		pc = '0;
		dropped = 1'b0;
		while (exp_addr.size() < ROW_BEATS) begin
			if (bm_at != 0 && !dropped && exp_addr.size() == bm_at) begin
				// rest of the pending bundle is killed
				pc = {pc[`FE_ADDR_W-1:4] + 1'b1, 4'b0000};
				dropped = 1'b1;
			end else begin
				w = mem[pc[11:4]][pc[3:2]];
				exp_addr.push_back(pc);
				exp_insn.push_back(w);
				if (w[`FE_INSN_W-1 -: 4] == OP_JC)
					pc = w[15:0];
				else if (w[`FE_INSN_W-1 -: 4] == OP_BR && w[`FE_INSN_W-5])
					pc = w[15:0];
				else if (w[`FE_INSN_W-1 -: 4] == OP_RET)
					pc = RET_ADDR;
				else if (pc[3:2] == 2'd2)
					pc = {pc[`FE_ADDR_W-1:4] + 1'b1, 4'b0000};
				else
					pc = pc + 16'd4;
			end
		end
	endtask

	task automatic reset_dut();
		@(negedge clk);
		rst = 1'b1;
		deq = 1'b0;
		branchmiss = 1'b0;
		repeat (RESET_CYC) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic run_row(int r);
		int    beats;
		int    phase;
		addr_t ea;
		insn_t ei;
		// bundle 0 jumps from its last slot to the row's start address
		set_slot(16'h0008, ctl_insn(OP_JC, 1'b0, row_start[r], 16'h0008));
		build_expected(row_bm[r]);
		reset_dut();
		beats = 0;
		// 0 holding deq low, 1 branchmiss out, 2 draining
		phase = row_hold[r] ? 0 : 2;
		deq = !row_hold[r];
		while (beats < ROW_BEATS) begin
			@(negedge clk);
			if (q_count > `FE_QDEPTH) begin
				$display("Error at %0t ns: q_count is %0d, expected at most %0d",
					$time, q_count, `FE_QDEPTH);
				level_errors++;
			end
			if (enq_valid) begin
				ea = exp_addr.pop_front();
				ei = exp_insn.pop_front();
				if (enq_addr !== ea) begin
					$display("Error at %0t ns: enq_addr is %h, expected %h",
						$time, enq_addr, ea);
					value_errors++;
				end
				if (enq_insn !== ei) begin
					$display("Error at %0t ns: enq_insn is %h, expected %h",
						$time, enq_insn, ei);
					value_errors++;
				end
				beats++;
			end
			if (phase == 0 && q_count == `FE_QDEPTH) begin
				if (row_bm[r] != 0) begin
					branchmiss = 1'b1;
					phase = 1;
				end else begin
					deq = 1'b1;
					phase = 2;
				end
			end else if (phase == 1) begin
				branchmiss = 1'b0;
				deq = 1'b1;
				phase = 2;
			end
		end
		beats_total += beats;
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		rst = 1'b1;
		deq = 1'b0;
		branchmiss = 1'b0;
		ret_addr = RET_ADDR;
		imem_hit = 1'b0;
		for (int s = 0; s < `FE_SLOTS; s++)
			imem_data[s] = '0;
		last_addr = '1;
		stable = 0;
		value_errors = 0;
		level_errors = 0;
		beats_total = 0;
		load_program();
		fill_rows();
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("%0d beats checked, %0d value errors, %0d queue level errors",
			beats_total, value_errors, level_errors);
		if (value_errors == 0 && level_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+rtl
rtl/fe_pkg.sv
rtl/bundle_if.sv
rtl/bundle_fetch.sv
rtl/slot_predecode.sv
rtl/slot_valid.sv
rtl/issue_queue.sv
rtl/front_end_top.sv
testbench/tb_front_end.sv

/* Bender.yml */
package:
  name: bundle_front_end

sources:
  # design, in compile order
  - include_dirs:
      - rtl
    files:
      - rtl/fe_pkg.sv
      - rtl/bundle_if.sv
      - rtl/bundle_fetch.sv
      - rtl/slot_predecode.sv
      - rtl/slot_valid.sv
      - rtl/issue_queue.sv
      - rtl/front_end_top.sv
  # testbench
  - target: simulation
    include_dirs:
      - rtl
    files:
      - testbench/tb_front_end.sv
